//--- sim.f
+incdir+verif
hw/mips_pkg.sv
hw/mips_ctrl_if.sv
hw/mips_cpu_alu.sv
hw/mips_cpu_regfile.sv
hw/mips_cpu_control.sv
hw/mips_cpu_datapath.sv
hw/mips_cpu_top.sv
verif/mips_tb.sv

//--- verif/mips_tb_model.svh
// Instruction-set model of the supported MIPS32 subset without delay slots
task automatic run_model();
    logic [31:0] regs [32];
    logic [31:0] pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] simm;
    logic [31:0] ea;
    logic [31:0] res;
    logic [4:0]  dest;
    logic        we;
    int          steps;
    pc = RESET_VECTOR;
    steps = 0;
    foreach (regs[i])
        regs[i] = 32'd0;
    while (pc != 32'd0 && steps < 2 * PROG_MAX) begin
        ins = model_mem[pc[13:2]];
        pc = pc + 32'd4;
        steps++;
        a = regs[ins[25:21]];
        b = regs[ins[20:16]];
        simm = {{16{ins[15]}}, ins[15:0]};
        ea = a + simm;
        dest = ins[20:16];  // rt unless R format
        we = 1'b1;
        res = 32'd0;
        case (ins[31:26])
            OP_RTYPE: begin
                dest = ins[15:11];
                case (ins[5:0])
                    F_ADDU:  res = a + b;
                    F_SUBU:  res = a - b;
                    F_AND:   res = a & b;
                    F_OR:    res = a | b;
                    F_XOR:   res = a ^ b;
                    F_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: we = 1'b0;
                endcase
            end
            OP_ADDIU: res = a + simm;
            OP_ANDI:  res = a & {16'd0, ins[15:0]};
            OP_ORI:   res = a | {16'd0, ins[15:0]};
            OP_LUI:   res = {ins[15:0], 16'd0};
            OP_LW:    res = model_mem[ea[13:2]];
            OP_SW: begin
                we = 1'b0;
                model_mem[ea[13:2]] = b;
                exp_addr.push_back(ea);
                exp_data.push_back(b);
            end
            OP_BEQ: begin
                we = 1'b0;
                if (a == b)
                    pc = pc + (simm << 2);
            end
            OP_BNE: begin
                we = 1'b0;
                if (a != b)
                    pc = pc + (simm << 2);
            end
            OP_J: begin
                we = 1'b0;
                pc = {pc[31:28], ins[25:0], 2'b00};
            end
            default: we = 1'b0;
        endcase
        if (we && dest != 5'd0)
            regs[dest] = res;  // r0 stays zero
    end
endtask

//--- verif/mips_tb.sv
`default_nettype none

module mips_tb;
    import mips_pkg::*;

    localparam logic [31:0] RESET_VECTOR = 32'h100;
    localparam logic [31:0] SEED         = 32'h5248_1964;
    localparam int NUM_TESTS    = 4;
    localparam int BODY_OPS     = 40;
    localparam int NUM_BRANCHES = 6;
    localparam int PROG_MAX     = 160;  // Longest program in instructions
    localparam int CYCLE_LIMIT  = NUM_TESTS * PROG_MAX * 4 * 4 + 1000;
    localparam int MEM_WORDS    = 4096;

    logic        clk;
    logic        reset;
    logic        waitrequest;
    logic [31:0] readdata;
    logic [31:0] address;
    logic        read;
    logic        write;
    logic [31:0] writedata;
    logic        active;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] model_mem [MEM_WORDS];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] prog_addr;
    int          prog_len;
    int          wait_run;
    int          cycles;
    int          errors;
    int          checks;
    int          writes_seen;
    int          exp_count;
    int          err_before;
    bit          first_read;
    funct_t      functs [6] = '{F_ADDU, F_SUBU, F_AND, F_OR, F_XOR, F_SLT};

    mips_cpu_top #(
        .RESET_VECTOR (RESET_VECTOR)
    ) dut0 (
        .clk         (clk),
        .reset       (reset),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .active      (active)
    );

    `include "mips_tb_model.svh"

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: the core did not halt within %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    // Memory slave with waitrequest high for at most 3 cycles in a row
    always @(negedge clk) begin
        if ((read || write) && wait_run < 3 && ($urandom % 3) == 0) begin
            waitrequest = 1'b1;
            wait_run++;
        end else begin
            waitrequest = 1'b0;
            wait_run = 0;
        end
        readdata = read ? mem[address[13:2]] : 'x;
    end

    always @(posedge clk) begin
        if (!reset) begin
            if (first_read) begin
                check("read", read, 32'd1);
                check("address", address, RESET_VECTOR);
                check("write", write, 32'd0);
                first_read = 1'b0;
            end
            if (write && !waitrequest) begin
                if (exp_addr.size() == 0) begin
                    errors++;
                    $display("** Error at %0t: bus write to %h beyond the expected stores",
                             $time, address);
                end else begin
                    check("address", address, exp_addr.pop_front());
                    check("writedata", writedata, exp_data.pop_front());
                end
                mem[address[13:2]] = writedata;
                writes_seen++;
            end
        end
    end

    function automatic logic [31:0] r_word(input funct_t f, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd);
        return {OP_RTYPE, rs, rt, rd, 5'd0, f};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[prog_addr[13:2]] = word;
        prog_addr += 4;
        prog_len++;
    endtask

    task automatic random_op();
        logic [4:0]  dest;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] offset;
        dest = 5'($urandom % 28);  // r28 keeps the data base
        rs = 5'($urandom);
        rt = 5'($urandom);
        offset = 16'(($urandom % 64) * 4);
        case ($urandom % 12)
            0, 1, 2, 3, 4, 5: emit(r_word(functs[$urandom % 6], rs, rt, dest));
            6:       emit(i_word(OP_ADDIU, rs, dest, 16'($urandom)));
            7:       emit(i_word(OP_ANDI, rs, dest, 16'($urandom)));
            8:       emit(i_word(OP_ORI, rs, dest, 16'($urandom)));
            9:       emit(i_word(OP_LUI, 5'd0, dest, 16'($urandom)));
            10:      emit(i_word(OP_LW, 5'd28, dest, offset));
            default: emit(i_word(OP_SW, 5'd28, rt, offset));
        endcase
    endtask

    task automatic build_program();
        logic [31:0] value;
        logic [4:0]  rs;
        logic [4:0]  rt;
        int          skip;
        prog_addr = RESET_VECTOR;
        prog_len = 0;
        for (int r = 1; r < 32; r++) begin
            value = (r == 28) ? 32'h1000 : $urandom;
            emit(i_word(OP_LUI, 5'd0, 5'(r), value[31:16]));
            emit(i_word(OP_ORI, 5'(r), 5'(r), value[15:0]));
        end
        repeat (BODY_OPS) random_op();
        repeat (NUM_BRANCHES) begin
            skip = 1 + $urandom % 3;
            rs = 5'($urandom);
            rt = ($urandom % 2) ? rs : 5'($urandom);  // Equal operands half the time
            emit(i_word(($urandom % 2) ? OP_BEQ : OP_BNE, rs, rt, 16'(skip)));
            repeat (skip) random_op();
        end
        for (int r = 0; r < 32; r++) begin
            emit(i_word(OP_SW, 5'd28, 5'(r), 16'(32'h1000 + 4 * r)));  // Dump region
        end
        emit({OP_J, 26'd0});
    endtask

    task automatic fill_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'(i) * 32'h9e37_79b9 + 32'h2545_f491;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        clk = 1'b0;
        reset = 1'b1;
        waitrequest = 1'b0;
        readdata = 32'd0;
        wait_run = 0;
        cycles = 0;
        errors = 0;
        checks = 0;
        first_read = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            @(negedge clk);
            reset = 1'b1;
            fill_memory();
            build_program();
            model_mem = mem;
            exp_addr.delete();
            exp_data.delete();
            run_model();
            exp_count = exp_addr.size();
            writes_seen = 0;
            err_before = errors;
            first_read = 1'b1;
            repeat (8) @(negedge clk);
            reset = 1'b0;
            @(posedge clk);
            while (active) @(posedge clk);
            repeat (20) begin
                @(posedge clk);
                if (read || write) begin
                    errors++;
                    $display("** Error at %0t: bus access after the core halted", $time);
                end
            end
            check("write count", writes_seen, exp_count);
            $display("test %0d: %0d instructions, %0d writes, %0d errors",
                     t, prog_len, writes_seen, errors - err_before);
        end
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/mips_cpu_top.sv
`default_nettype none

module mips_cpu_top #(
    parameter logic [31:0] RESET_VECTOR = 32'hbfc0_0000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        waitrequest,
    input  logic [31:0] readdata,
    output logic [31:0] address,
    output logic        read,
    output logic        write,
    output logic [31:0] writedata,
    output logic        active
);

    mips_ctrl_if ctrl_bus ();

    mips_cpu_control ctrl0 (
        .clk         (clk),
        .reset       (reset),
        .waitrequest (waitrequest),
        .ctrl        (ctrl_bus.ctrl),
        .active      (active)
    );

    mips_cpu_datapath #(
        .RESET_VECTOR (RESET_VECTOR)
    ) dp0 (
        .clk       (clk),
        .reset     (reset),
        .dp        (ctrl_bus.dp),
        .readdata  (readdata),
        .address   (address),
        .writedata (writedata)
    );

    assign read  = ctrl_bus.mem_read;
    assign write = ctrl_bus.mem_write;

endmodule

`default_nettype wire

//--- hw/mips_cpu_datapath.sv
`default_nettype none

module mips_cpu_datapath #(
    parameter logic [31:0] RESET_VECTOR = 32'hbfc0_0000
) (
    input  logic        clk,
    input  logic        reset,
    mips_ctrl_if.dp     dp,
    input  logic [31:0] readdata,
    output logic [31:0] address,
    output logic [31:0] writedata
);
    import mips_pkg::*;

    logic [31:0] pc;
    instr_t      ir;
    logic [31:0] mdr;
    logic [31:0] reg_a;
    logic [31:0] reg_b;
    logic [31:0] alu_out;

    logic [31:0] imm_ext;
    logic [31:0] src_a;
    logic [31:0] src_b;
    logic [31:0] alu_result;
    logic [31:0] jump_target;
    logic [31:0] pc_next;
    logic        pc_load;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [4:0]  reg_waddr;
    logic [31:0] reg_wdata;

    assign imm_ext = dp.extend ? {16'd0, ir.i.imm16} : {{16{ir.i.imm16[15]}}, ir.i.imm16};

    assign src_a = dp.alu_src_a ? reg_a : pc;

    always_comb begin
        case (dp.alu_src_b)
            2'd0:    src_b = reg_b;
            2'd1:    src_b = 32'd4;
            2'd2:    src_b = imm_ext;
            default: src_b = {imm_ext[29:0], 2'b00};  // Branch offset
        endcase
    end

    mips_cpu_alu alu0 (
        .a      (src_a),
        .b      (src_b),
        .op     (dp.alu_op),
        .result (alu_result),
        .zero   (dp.zero)
    );

    assign reg_waddr = dp.reg_dest ? ir.r.rd : ir.i.rt;
    assign reg_wdata = dp.reg_data_sel ? mdr : alu_result;

    mips_cpu_regfile regfile0 (
        .clk     (clk),
        .rs      (ir.r.rs),
        .rt      (ir.r.rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .rd      (reg_waddr),
        .wdata   (reg_wdata),
        .we      (dp.reg_write)
    );

    assign jump_target = {pc[31:28], ir.j.target26, 2'b00};

    always_comb begin
        case (dp.pc_src)
            2'd0:    pc_next = alu_result;
            2'd1:    pc_next = jump_target;
            default: pc_next = alu_out;
        endcase
    end

    assign pc_load = dp.pc_write || (dp.pc_write_cond && dp.zero);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_VECTOR;
        end else if (pc_load) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (dp.ir_write) begin
            ir <= readdata;
        end
        mdr     <= readdata;
        reg_a   <= rs_data;
        reg_b   <= rt_data;
        alu_out <= alu_result;
    end

    // Data address straight from the ALU so EX can start the transfer
    assign address    = dp.iod ? alu_result : pc;
    assign writedata  = reg_b;
    assign dp.address = address;
    assign dp.op      = ir.r.op;
    assign dp.funct   = ir.r.funct;

    assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- hw/mips_cpu_control.sv
`default_nettype none

module mips_cpu_control (
    input  logic      clk,
    input  logic      reset,
    input  logic      waitrequest,
    mips_ctrl_if.ctrl ctrl,
    output logic      active
);
    import mips_pkg::*;

    state_t      state;
    instr_type_t instr_type;
    logic        mem_access;

    always_comb begin
        case (ctrl.op)
            OP_LW:   instr_type = IT_LOAD;
            OP_SW:   instr_type = IT_STORE;
            default: instr_type = IT_OTHER;
        endcase
    end

    assign mem_access = (instr_type != IT_OTHER);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IF;
        end else if (ctrl.address == 32'd0) begin
            state <= STP;  // Halt for good
        end else begin
            case (state)
                IF: begin
                    if (!waitrequest) begin
                        state <= ID;
                    end
                end
                ID: begin
                    state <= EX;
                end
                EX: begin
                    if (mem_access && waitrequest) begin
                        state <= EX;  // Bus transfer pending
                    end else if (instr_type == IT_LOAD) begin
                        state <= MEM;
                    end else begin
                        state <= IF;
                    end
                end
                MEM: begin
                    state <= IF;
                end
                default: begin
                    state <= STP;
                end
            endcase
        end
    end

    assign active = (state != STP) && !reset;

    always_comb begin
        ctrl.mem_write     = 1'b0;
        ctrl.mem_read      = 1'b0;
        ctrl.reg_data_sel  = 1'b0;
        ctrl.reg_dest      = 1'b0;
        ctrl.reg_write     = 1'b0;
        ctrl.ir_write      = 1'b0;
        ctrl.alu_src_a     = 1'b0;
        ctrl.alu_src_b     = 2'd0;
        ctrl.alu_op        = ALU_ADD;
        ctrl.pc_src        = 2'd0;
        ctrl.pc_write      = 1'b0;
        ctrl.pc_write_cond = 1'b0;
        ctrl.iod           = 1'b0;
        ctrl.extend        = 1'b0;
        case (state)
            IF: begin
                ctrl.mem_read  = 1'b1;
                ctrl.ir_write  = !waitrequest;
                ctrl.pc_write  = !waitrequest;
                ctrl.alu_src_b = 2'd1;  // PC + 4
            end
            ID: begin
                ctrl.alu_src_b = 2'd3;  // Branch target into ALU out reg
            end
            EX: begin
                ctrl.alu_src_a = 1'b1;
                case (ctrl.op)
                    OP_RTYPE: begin
                        ctrl.reg_dest  = 1'b1;
                        ctrl.reg_write = 1'b1;
                        case (ctrl.funct)
                            F_ADDU:  ctrl.alu_op = ALU_ADD;
                            F_SUBU:  ctrl.alu_op = ALU_SUB;
                            F_AND:   ctrl.alu_op = ALU_AND;
                            F_OR:    ctrl.alu_op = ALU_OR;
                            F_XOR:   ctrl.alu_op = ALU_XOR;
                            F_SLT:   ctrl.alu_op = ALU_SLT;
                            default: ctrl.reg_write = 1'b0;
                        endcase
                    end
                    OP_ADDIU: begin
                        ctrl.alu_src_b = 2'd2;
                        ctrl.reg_write = 1'b1;
                    end
                    OP_ANDI: begin
                        ctrl.alu_src_b = 2'd2;
                        ctrl.alu_op    = ALU_AND;
                        ctrl.extend    = 1'b1;
                        ctrl.reg_write = 1'b1;
                    end
                    OP_ORI: begin
                        ctrl.alu_src_b = 2'd2;
                        ctrl.alu_op    = ALU_OR;
                        ctrl.extend    = 1'b1;
                        ctrl.reg_write = 1'b1;
                    end
                    OP_LUI: begin
                        ctrl.alu_src_b = 2'd2;
                        ctrl.alu_op    = ALU_LUI;
                        ctrl.reg_write = 1'b1;
                    end
                    OP_BEQ, OP_BNE: begin
                        ctrl.alu_op        = (ctrl.op == OP_BEQ) ? ALU_EQ : ALU_NE;
                        ctrl.pc_src        = 2'd2;
                        ctrl.pc_write_cond = 1'b1;
                    end
                    OP_J: begin
                        ctrl.alu_op   = ALU_PASS;
                        ctrl.pc_src   = 2'd1;
                        ctrl.pc_write = 1'b1;
                    end
                    OP_LW: begin
                        ctrl.alu_src_b = 2'd2;
                        ctrl.mem_read  = 1'b1;
                        ctrl.iod       = 1'b1;
                    end
                    OP_SW: begin
                        ctrl.alu_src_b = 2'd2;
                        ctrl.mem_write = 1'b1;
                        ctrl.iod       = 1'b1;
                    end
                    default: begin
                        ctrl.alu_op = ALU_PASS;  // Unsupported opcode acts as a nop
                    end
                endcase
            end
            MEM: begin
                ctrl.reg_data_sel = 1'b1;  // Load writeback
                ctrl.reg_write    = 1'b1;
            end
            default: begin
                ctrl.extend = 1'b0;
            end
        endcase
    end

    assert property (@(posedge clk) disable iff (reset)
        !(ctrl.mem_read && ctrl.mem_write));

    assert property (@(posedge clk) disable iff (reset)
        (state inside {IF, ID}) |-> !ctrl.reg_write);

endmodule

`default_nettype wire

//--- hw/mips_cpu_regfile.sv
`default_nettype none

module mips_cpu_regfile (
    input  logic        clk,
    input  logic [4:0]  rs,
    input  logic [4:0]  rt,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    input  logic [4:0]  rd,
    input  logic [31:0] wdata,
    input  logic        we
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (we && (rd != 5'd0)) begin
            regs[rd] <= wdata;
        end
    end

    assign rs_data = (rs == 5'd0) ? 32'd0 : regs[rs];  // r0 reads zero
    assign rt_data = (rt == 5'd0) ? 32'd0 : regs[rt];

endmodule

`default_nettype wire

//--- hw/mips_cpu_alu.sv
`default_nettype none

module mips_cpu_alu (
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    input  mips_pkg::alu_op_t op,
    output logic [31:0]       result,
    output logic              zero
);
    import mips_pkg::*;

    logic less;

    assign less = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLT:  result = {31'd0, less};
            ALU_LUI:  result = {b[15:0], 16'd0};
            ALU_EQ:   result = a ^ b;  // Zero when equal
            ALU_NE:   result = a ^ b;
            ALU_PASS: result = a;
            default:  result = 32'd0;
        endcase
    end

    // One flag for both branch conditions
    assign zero = (op == ALU_NE) ? (result != 32'd0) : (result == 32'd0);

endmodule

`default_nettype wire

//--- hw/mips_ctrl_if.sv
`default_nettype none

interface mips_ctrl_if;
    import mips_pkg::*;

    logic        mem_write;
    logic        mem_read;
    logic        reg_data_sel;  // 1 selects memory data register
    logic        reg_dest;      // 1 selects rd
    logic        reg_write;
    logic        ir_write;
    logic        alu_src_a;     // 1 selects register A
    logic [1:0]  alu_src_b;     // B, 4, imm, imm << 2
    alu_op_t     alu_op;
    logic [1:0]  pc_src;        // ALU, jump target, ALU out reg
    logic        pc_write;
    logic        pc_write_cond;
    logic        iod;
    logic        extend;        // 1 zero-extends immediate

    opcode_t     op;
    funct_t      funct;
    logic        zero;
    logic [31:0] address;

    modport ctrl (
        output mem_write, mem_read, reg_data_sel, reg_dest, reg_write, ir_write,
               alu_src_a, alu_src_b, alu_op, pc_src, pc_write, pc_write_cond,
               iod, extend,
        input  op, funct, zero, address
    );

    modport dp (
        input  mem_write, mem_read, reg_data_sel, reg_dest, reg_write, ir_write,
               alu_src_a, alu_src_b, alu_op, pc_src, pc_write, pc_write_cond,
               iod, extend,
        output op, funct, zero, address
    );

endinterface

`default_nettype wire

//--- hw/mips_pkg.sv
`default_nettype none

package mips_pkg;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_J     = 6'b000010,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_ADDIU = 6'b001001,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_LUI   = 6'b001111,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcode_t;

    typedef enum logic [5:0] {
        F_ADDU = 6'b100001,
        F_SUBU = 6'b100011,
        F_AND  = 6'b100100,
        F_OR   = 6'b100101,
        F_XOR  = 6'b100110,
        F_SLT  = 6'b101010
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_LUI  = 4'd6,
        ALU_EQ   = 4'd7,
        ALU_NE   = 4'd8,
        ALU_PASS = 4'd9
    } alu_op_t;

    typedef struct packed {
        opcode_t    op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_t     funct;
    } r_format_t;

    typedef struct packed {
        opcode_t     op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_format_t;

    typedef struct packed {
        opcode_t     op;
        logic [25:0] target26;
    } j_format_t;

    // Three views of one fetched word
    typedef union packed {
        r_format_t r;
        i_format_t i;
        j_format_t j;
    } instr_t;

    typedef enum logic [2:0] {
        IF  = 3'd0,
        ID  = 3'd1,
        EX  = 3'd2,
        MEM = 3'd3,
        STP = 3'd4
    } state_t;

    typedef enum logic [1:0] {
        IT_OTHER = 2'd0,
        IT_STORE = 2'd1,
        IT_LOAD  = 2'd2
    } instr_type_t;

endpackage

`default_nettype wire
